// ==== common/mcb_macros.svh ====
`ifndef MCB_MACROS_SVH
`define MCB_MACROS_SVH

//----------------------------------------------------------
// USI bus master subsystem sizing
//----------------------------------------------------------

// Slaves hung on the bus, at most 16
`define MCB_SLAVE_COUNT 4

// USI address width, command bit included
`define MCB_BUS_ADRS_BIT 16

// Words held by each register slave
`define MCB_SLAVE_REGS 4

// Cycles a read may stay open before the error flag
`define MCB_READ_TIMEOUT 8

`endif

// ==== common/UsiBusPkg.sv ====
`include "mcb_macros.svh"

package UsiBusPkg;

	//----------------------------------------------------------
	// USI bus fields
	//----------------------------------------------------------
	typedef logic [31:0] usiDataT;
	typedef logic [`MCB_BUS_ADRS_BIT-1:0] usiAdrsT;

	// Target slave, address bits 15..12
	typedef logic [3:0] usiSlaveIdT;

	// Command bit, address bit 11
	typedef enum logic
	{
		usiCmdRead = 1'b0,
		usiCmdWrite = 1'b1
	} usiCmdT;

	// Register inside a slave, address bits 1..0
	typedef logic [1:0] usiRegIdxT;

	// Field decoders
	function automatic usiSlaveIdT usiSlaveId(input usiAdrsT adrs);
		return adrs[15:12];
	endfunction

	function automatic usiCmdT usiCmd(input usiAdrsT adrs);
		return usiCmdT'(adrs[11]);
	endfunction

	function automatic usiRegIdxT usiRegIdx(input usiAdrsT adrs);
		return adrs[1:0];
	endfunction

endpackage

// ==== common/McbCsrPkg.sv ====
package McbCsrPkg;

	//----------------------------------------------------------
	// Host visible CSR map
	//----------------------------------------------------------
	typedef enum logic [7:0]
	{
		csrWdata = 8'd0,	// data for next command
		csrAdrs = 8'd1,		// USI address incl. command bit
		csrGo = 8'd2,		// any write fires the command
		csrRdata = 8'd3,	// last read return
		csrStatus = 8'd4
	} mcbCsrAdrsT;

	// Status word
	typedef struct packed
	{
		logic [11:0] rsvdHigh;
		// Valid vector seen with the last return
		logic [15:0] slaveValid;
		logic [1:0] rsvdLow;
		// Read timed out
		logic error;
		// Read in flight
		logic busy;
	} mcbStatusT;

endpackage

// ==== src/UsiSlaveRegs.sv ====
`include "mcb_macros.svh"

module UsiSlaveRegs
	import UsiBusPkg::*;
#(
	parameter usiSlaveIdT slaveId = '0
)(
	input logic sysClk,
	input logic reset,
	// Broadcast command from the master
	input usiDataT usiWd,
	input usiAdrsT usiAdrs,
	input logic usiWEd,
	// Read return is zero when idle
	output usiDataT slvRd,
	output logic slvVd
);

	usiDataT regs [`MCB_SLAVE_REGS];
	logic hit;
	usiRegIdxT regIdx;

	// Address decode
	assign hit = usiWEd && (usiSlaveId(usiAdrs) == slaveId);
	assign regIdx = usiRegIdx(usiAdrs);

	//----------------------------------------------------------
	// Register file and read return
	//----------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `MCB_SLAVE_REGS; i++)
				regs[i] <= '0;
			slvRd <= '0;
			slvVd <= 1'b0;
		end
		else
		begin
			slvRd <= '0;
			slvVd <= 1'b0;
			if (hit && (usiCmd(usiAdrs) == usiCmdWrite))
				regs[regIdx] <= usiWd;
			else if (hit)
			begin
				// One pulse with the addressed word
				slvRd <= regs[regIdx];
				slvVd <= 1'b1;
			end
		end
	end

endmodule

// ==== src/UsiReadCollector.sv ====
`include "mcb_macros.svh"

module UsiReadCollector
	import UsiBusPkg::*;
(
	input logic sysClk,
	input logic reset,
	input usiDataT slvRd [`MCB_SLAVE_COUNT],
	input logic [`MCB_SLAVE_COUNT-1:0] slvVd,
	output usiDataT usiRd,
	output logic [`MCB_SLAVE_COUNT-1:0] usiVd
);

	usiDataT mergedRd;

	// Idle slaves drive zero, so OR is a mux
	always_comb
	begin
		mergedRd = '0;
		for (int i = 0; i < `MCB_SLAVE_COUNT; i++)
			mergedRd = mergedRd | slvRd[i];
	end

	// Registered return toward the master
	always_ff @(posedge sysClk)
	begin
		if (reset)
		begin
			usiRd <= '0;
			usiVd <= '0;
		end
		else
		begin
			usiRd <= mergedRd;
			usiVd <= slvVd;
		end
	end

endmodule

// ==== microController/MicroControllerCsr.sv ====
`include "mcb_macros.svh"

module MicroControllerCsr
	import UsiBusPkg::*;
	import McbCsrPkg::*;
(
	input logic sysClk,
	input logic reset,
	// CSR access from the handshake FSM
	input usiDataT csrWd,
	input mcbCsrAdrsT csrAdrs,
	input logic csrWr,
	input logic csrCke,
	output usiDataT csrRd,
	// Read return from the collector
	input usiDataT usiRd,
	input logic [`MCB_SLAVE_COUNT-1:0] usiVd,
	// Command and address share one port
	output usiDataT usiWd,
	output usiAdrsT usiAdrs,
	output logic usiWEd
);

	localparam int waitCntBit = $clog2(`MCB_READ_TIMEOUT + 1);
	localparam logic [waitCntBit-1:0] waitLast = waitCntBit'(`MCB_READ_TIMEOUT - 1);

	usiDataT wdataReg;
	usiAdrsT adrsReg;
	usiDataT rdataReg;
	mcbStatusT statusReg;
	logic [waitCntBit-1:0] waitCnt;
	logic goWrite;

	// Bus side is the held wdata and address
	assign usiWd = wdataReg;
	assign usiAdrs = adrsReg;

	// Go accepted only when idle
	assign goWrite = csrCke && csrWr && (csrAdrs == McbCsrPkg::csrGo) && !statusReg.busy;

	//----------------------------------------------------------
	// Register writes, command issue, return and timeout
	//----------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (reset)
		begin
			wdataReg <= '0;
			adrsReg <= '0;
			rdataReg <= '0;
			statusReg <= '0;
			waitCnt <= '0;
			usiWEd <= 1'b0;
		end
		else
		begin
			usiWEd <= goWrite;
			if (csrCke && csrWr && (csrAdrs == McbCsrPkg::csrWdata))
				wdataReg <= csrWd;
			if (csrCke && csrWr && (csrAdrs == McbCsrPkg::csrAdrs))
				adrsReg <= usiAdrsT'(csrWd);

			if (goWrite)
			begin
				statusReg.error <= 1'b0;
				waitCnt <= '0;
				// Only reads wait for a return
				if (usiCmd(adrsReg) == usiCmdRead)
					statusReg.busy <= 1'b1;
			end
			else if (statusReg.busy)
			begin
				if (|usiVd)
				begin
					rdataReg <= usiRd;
					statusReg.slaveValid <= 16'(usiVd);
					statusReg.busy <= 1'b0;
				end
				else if (waitCnt == waitLast)
				begin
					// No slave answered
					statusReg.busy <= 1'b0;
					statusReg.error <= 1'b1;
					statusReg.slaveValid <= '0;
				end
				else
					waitCnt <= waitCnt + waitCntBit'(1);
			end
		end
	end

	//----------------------------------------------------------
	// Read mux for the host
	//----------------------------------------------------------
	always_comb
	begin
		case (csrAdrs)
			McbCsrPkg::csrWdata:	csrRd = wdataReg;
			McbCsrPkg::csrAdrs:		csrRd = usiDataT'(adrsReg);
			McbCsrPkg::csrRdata:	csrRd = rdataReg;
			McbCsrPkg::csrStatus:	csrRd = statusReg;
			// Go and unmapped read as zero
			default:				csrRd = '0;
		endcase
	end

endmodule

// ==== microController/MicroControllerBlock.sv ====
`include "mcb_macros.svh"

module MicroControllerBlock
	import UsiBusPkg::*;
	import McbCsrPkg::*;
(
	input logic sysClk,
	input logic reset,
	// Four-phase host command port
	input logic hostReq,
	input logic hostWr,
	input logic [7:0] hostAdrs,
	input usiDataT hostWd,
	output logic hostAck,
	output usiDataT hostRd,
	// USI master side
	input usiDataT usiRd,
	input logic [`MCB_SLAVE_COUNT-1:0] usiVd,
	output usiDataT usiWd,
	output usiAdrsT usiAdrs,
	output logic usiWEd
);

	//----------------------------------------------------------
	// Handshake FSM
	//----------------------------------------------------------
	typedef enum logic [1:0]
	{
		stIdle,
		stStrobe,
		stAck
	} hsStateT;

	hsStateT state;

	// Host command, held for the CSR
	usiDataT csrWd;
	mcbCsrAdrsT csrAdrs;
	logic csrWr;
	logic csrCke;
	usiDataT csrRd;

	always_ff @(posedge sysClk)
	begin
		if (reset)
		begin
			state <= stIdle;
			csrCke <= 1'b0;
			hostAck <= 1'b0;
			hostRd <= '0;
			csrWd <= '0;
			csrAdrs <= mcbCsrAdrsT'(8'd0);
			csrWr <= 1'b0;
		end
		else
		begin
			case (state)
				stIdle:
				begin
					// Ack drops one cycle after req seen low
					hostAck <= 1'b0;
					if (hostReq)
					begin
						csrWd <= hostWd;
						csrAdrs <= mcbCsrAdrsT'(hostAdrs);
						csrWr <= hostWr;
						csrCke <= 1'b1;
						state <= stStrobe;
					end
				end
				stStrobe:
				begin
					// Single strobe per request
					csrCke <= 1'b0;
					// Value from before the CSR side effect
					hostRd <= csrRd;
					state <= stAck;
				end
				default:
				begin
					if (hostReq)
						hostAck <= 1'b1;
					else
						state <= stIdle;
				end
			endcase
		end
	end

	//----------------------------------------------------------
	// CSR space and USI command issue
	//----------------------------------------------------------
	MicroControllerCsr microControllerCsr (
		.sysClk		(sysClk),
		.reset		(reset),
		.csrWd		(csrWd),
		.csrAdrs	(csrAdrs),
		.csrWr		(csrWr),
		.csrCke		(csrCke),
		.csrRd		(csrRd),
		.usiRd		(usiRd),
		.usiVd		(usiVd),
		.usiWd		(usiWd),
		.usiAdrs	(usiAdrs),
		.usiWEd		(usiWEd)
	);

endmodule

// ==== src/UsiSubsystem.sv ====
`include "mcb_macros.svh"

module UsiSubsystem
	import UsiBusPkg::*;
(
	input logic sysClk,
	input logic reset,
	input logic hostReq,
	input logic hostWr,
	input logic [7:0] hostAdrs,
	input usiDataT hostWd,
	output logic hostAck,
	output usiDataT hostRd
);

	//----------------------------------------------------------
	// USI bus wires
	//----------------------------------------------------------
	usiDataT usiWd;
	usiAdrsT usiAdrs;
	logic usiWEd;
	usiDataT usiRd;
	logic [`MCB_SLAVE_COUNT-1:0] usiVd;
	usiDataT slvRd [`MCB_SLAVE_COUNT];
	logic [`MCB_SLAVE_COUNT-1:0] slvVd;

	// Bus master with host port
	MicroControllerBlock microControllerBlock (
		.sysClk		(sysClk),
		.reset		(reset),
		.hostReq	(hostReq),
		.hostWr		(hostWr),
		.hostAdrs	(hostAdrs),
		.hostWd		(hostWd),
		.hostAck	(hostAck),
		.hostRd		(hostRd),
		.usiRd		(usiRd),
		.usiVd		(usiVd),
		.usiWd		(usiWd),
		.usiAdrs	(usiAdrs),
		.usiWEd		(usiWEd)
	);

	// One register slave per bus id
	for (genvar i = 0; i < `MCB_SLAVE_COUNT; i++)
	begin : gSlave
		UsiSlaveRegs #(
			.slaveId	(usiSlaveIdT'(i))
		) usiSlaveRegs (
			.sysClk		(sysClk),
			.reset		(reset),
			.usiWd		(usiWd),
			.usiAdrs	(usiAdrs),
			.usiWEd		(usiWEd),
			.slvRd		(slvRd[i]),
			.slvVd		(slvVd[i])
		);
	end

	// Single drain point back to the master
	UsiReadCollector usiReadCollector (
		.sysClk		(sysClk),
		.reset		(reset),
		.slvRd		(slvRd),
		.slvVd		(slvVd),
		.usiRd		(usiRd),
		.usiVd		(usiVd)
	);

endmodule

// ==== verif/UsiSubsystemTb.sv ====
`include "mcb_macros.svh"

module UsiSubsystemTb
	import UsiBusPkg::*;
	import McbCsrPkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int clkPeriod = 4;
	localparam int randCount = 64;
	localparam int cyclesPerTest = 40;

	typedef enum {opCsrWrite, opCsrRead, opBusWrite, opBusRead} stimOpT;

	// One row of the stimulus table
	typedef struct
	{
		string name;
		stimOpT op;
		int slave;
		int regIdx;
		usiDataT data;
		usiDataT expected;
	} stimEntryT;

	logic sysClk = 1'b0;
	logic reset;
	logic hostReq;
	logic hostWr;
	logic [7:0] hostAdrs;
	usiDataT hostWd;
	logic hostAck;
	usiDataT hostRd;

	stimEntryT stimTable [$];
	// Reference copy of every slave register
	usiDataT model [`MCB_SLAVE_COUNT][`MCB_SLAVE_REGS];
	int writtenSlave [$];
	int writtenReg [$];
	integer seed = 32'hf32e6e62;

	always #(clkPeriod / 2) sysClk = ~sysClk;

	UsiSubsystem i_UsiSubsystem (
		.sysClk		(sysClk),
		.reset		(reset),
		.hostReq	(hostReq),
		.hostWr		(hostWr),
		.hostAdrs	(hostAdrs),
		.hostWd		(hostWd),
		.hostAck	(hostAck),
		.hostRd		(hostRd)
	);

	//------------------------------------------------------------
	// Error reporting and checks
	//------------------------------------------------------------
	task automatic reportFailure(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkValue(input string name, input usiDataT expected, input usiDataT actual);
		assert (actual === expected)
		else
			reportFailure($sformatf("CHECK FAILED %s: expected %h, actual %h",
				name, expected, actual));
	endtask

	// Ack only follows req
	always @(posedge hostAck)
	begin
		assert (hostReq === 1'b1)
		else
			reportFailure("Handshake error: hostAck rose while hostReq was low");
	end

	always @(negedge hostAck)
	begin
		if (!reset)
		begin
			assert (hostReq === 1'b0)
			else
				reportFailure("Handshake error: hostAck fell while hostReq was still high");
		end
	end

	//------------------------------------------------------------
	// Expected values from the address and status rules
	//------------------------------------------------------------
	// Slave in 15..12, command in 11, register in 1..0
	function automatic usiDataT busAddress(input int slave, input int regIdx, input logic isWrite);
		usiAdrsT adrs;
		adrs = '0;
		adrs[15:12] = 4'(slave);
		adrs[11] = isWrite;
		adrs[1:0] = 2'(regIdx);
		return usiDataT'(adrs);
	endfunction

	// Valid bit of the slave, or error alone for a missing slave
	function automatic usiDataT statusFor(input int slave);
		if (slave >= `MCB_SLAVE_COUNT)
			return 32'h2;
		return 32'h10 << slave;
	endfunction

	//------------------------------------------------------------
	// Four-phase host port
	//------------------------------------------------------------
	task automatic hostAccess(input logic wr, input mcbCsrAdrsT adrs, input usiDataT wd,
		output usiDataT rd);
		@(negedge sysClk);
		hostWr = wr;
		hostAdrs = adrs;
		hostWd = wd;
		hostReq = 1'b1;
		@(posedge hostAck);
		@(negedge sysClk);
		// Read data valid while ack is high
		rd = hostRd;
		hostReq = 1'b0;
		@(negedge hostAck);
	endtask

	task automatic hostWrite(input mcbCsrAdrsT adrs, input usiDataT wd);
		usiDataT unused;
		hostAccess(1'b1, adrs, wd, unused);
	endtask

	task automatic hostRead(input mcbCsrAdrsT adrs, output usiDataT rd);
		hostAccess(1'b0, adrs, '0, rd);
	endtask

	//------------------------------------------------------------
	// USI commands through the CSR space
	//------------------------------------------------------------
	task automatic busWrite(input int slave, input int regIdx, input usiDataT data);
		hostWrite(csrWdata, data);
		hostWrite(csrAdrs, busAddress(slave, regIdx, 1'b1));
		hostWrite(csrGo, '0);
		// Missing slaves keep nothing
		if (slave < `MCB_SLAVE_COUNT)
		begin
			model[slave][regIdx] = data;
			writtenSlave.push_back(slave);
			writtenReg.push_back(regIdx);
		end
	endtask

	task automatic busRead(input int slave, input int regIdx, output usiDataT rdata,
		output usiDataT status);
		hostWrite(csrAdrs, busAddress(slave, regIdx, 1'b0));
		hostWrite(csrGo, '0);
		// Until return or timeout
		do
			hostRead(csrStatus, status);
		while (status[0]);
		hostRead(csrRdata, rdata);
	endtask

	//------------------------------------------------------------
	// Stimulus table
	//------------------------------------------------------------
	task automatic addStim(input string name, input stimOpT op, input int slave, input int regIdx,
		input usiDataT data, input usiDataT expected);
		stimEntryT entry;
		entry.name = name;
		entry.op = op;
		entry.slave = slave;
		entry.regIdx = regIdx;
		entry.data = data;
		entry.expected = expected;
		stimTable.push_back(entry);
	endtask

	task automatic buildTable();
		// Reset values and CSR readback
		addStim("rdataAfterReset", opCsrRead, 0, int'(csrRdata), 32'h0, 32'h0);
		addStim("statusAfterReset", opCsrRead, 0, int'(csrStatus), 32'h0, 32'h0);
		addStim("wdataWrite", opCsrWrite, 0, int'(csrWdata), 32'h5a5a_1234, 32'h0);
		addStim("wdataReadback", opCsrRead, 0, int'(csrWdata), 32'h0, 32'h5a5a_1234);
		// One word into each slave
		addStim("writeS0R0", opBusWrite, 0, 0, 32'h1111_0000, 32'h0);
		addStim("writeS1R1", opBusWrite, 1, 1, 32'h2222_1111, 32'h0);
		addStim("writeS2R2", opBusWrite, 2, 2, 32'h3333_2222, 32'h0);
		addStim("writeS3R3", opBusWrite, 3, 3, 32'h4444_3333, 32'h0);
		addStim("readS0R0", opBusRead, 0, 0, 32'h0, 32'h1111_0000);
		addStim("readS1R1", opBusRead, 1, 1, 32'h0, 32'h2222_1111);
		addStim("readS2R2", opBusRead, 2, 2, 32'h0, 32'h3333_2222);
		addStim("readS3R3", opBusRead, 3, 3, 32'h0, 32'h4444_3333);
		// Untouched registers stay zero
		addStim("untouchedS0R1", opBusRead, 0, 1, 32'h0, 32'h0);
		addStim("untouchedS2R0", opBusRead, 2, 0, 32'h0, 32'h0);
		// Overwrite leaves the other slaves alone
		addStim("overwriteS1R1", opBusWrite, 1, 1, 32'h5555_6666, 32'h0);
		addStim("otherSlaveKept", opBusRead, 3, 3, 32'h0, 32'h4444_3333);
		addStim("overwriteRead", opBusRead, 1, 1, 32'h0, 32'h5555_6666);
		// Missing slaves time out and rdata holds
		addStim("missingSlaveFirst", opBusRead, `MCB_SLAVE_COUNT, 0, 32'h0, 32'h5555_6666);
		addStim("missingSlaveLast", opBusRead, 15, 2, 32'h0, 32'h5555_6666);
		addStim("errorClears", opBusRead, 2, 2, 32'h0, 32'h3333_2222);
	endtask

	task automatic applyStim(input stimEntryT e);
		usiDataT rdata;
		usiDataT status;
		case (e.op)
			opCsrWrite:
				hostWrite(mcbCsrAdrsT'(8'(e.regIdx)), e.data);
			opCsrRead:
			begin
				hostRead(mcbCsrAdrsT'(8'(e.regIdx)), rdata);
				checkValue(e.name, e.expected, rdata);
			end
			opBusWrite:
				busWrite(e.slave, e.regIdx, e.data);
			default:
			begin
				busRead(e.slave, e.regIdx, rdata, status);
				checkValue(e.name, e.expected, rdata);
				checkValue({e.name, "Status"}, statusFor(e.slave), status);
			end
		endcase
	endtask

	// Random write, then read back some earlier location
	task automatic randomPhase();
		int slave;
		int regIdx;
		int pick;
		usiDataT data;
		usiDataT rdata;
		usiDataT status;
		for (int n = 0; n < randCount; n++)
		begin
			slave = int'($unsigned($random(seed)) % 32'(`MCB_SLAVE_COUNT));
			regIdx = int'($unsigned($random(seed)) % 32'(`MCB_SLAVE_REGS));
			data = $random(seed);
			busWrite(slave, regIdx, data);
			pick = int'($unsigned($random(seed)) % 32'(writtenSlave.size()));
			slave = writtenSlave[pick];
			regIdx = writtenReg[pick];
			busRead(slave, regIdx, rdata, status);
			checkValue($sformatf("random%0d", n), model[slave][regIdx], rdata);
			checkValue($sformatf("random%0dStatus", n), statusFor(slave), status);
		end
	endtask

	task automatic watchdog();
		int limit;
		limit = (stimTable.size() + randCount) * cyclesPerTest;
		#(limit * clkPeriod);
		reportFailure("Watchdog expired: the run did not finish in time");
	endtask

	//------------------------------------------------------------
	// Main sequence
	//------------------------------------------------------------
	initial
	begin
		reset = 1'b1;
		hostReq = 1'b0;
		hostWr = 1'b0;
		hostAdrs = '0;
		hostWd = '0;
		for (int s = 0; s < `MCB_SLAVE_COUNT; s++)
			for (int r = 0; r < `MCB_SLAVE_REGS; r++)
				model[s][r] = '0;
		buildTable();
		fork
			watchdog();
		join_none
		repeat (4) @(posedge sysClk);
		@(negedge sysClk);
		reset = 1'b0;
		foreach (stimTable[i])
			applyStim(stimTable[i]);
		randomPhase();
		$display("TEST OK");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+common
common/UsiBusPkg.sv
common/McbCsrPkg.sv
src/UsiSlaveRegs.sv
src/UsiReadCollector.sv
microController/MicroControllerCsr.sv
microController/MicroControllerBlock.sv
src/UsiSubsystem.sv
verif/UsiSubsystemTb.sv

// ==== Makefile ====
# Verilator build and run of the USI subsystem testbench

VERILATOR ?= verilator
TOP ?= UsiSubsystemTb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := common/mcb_macros.svh
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TEST OK" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
